/* common/elink_pkg.sv */
package elink_pkg;

   // Mesh transaction encodings
   typedef enum logic
   {
      ACC_READ  = 1'b0,
      ACC_WRITE = 1'b1
   } access_e;

   typedef enum logic [1:0]
   {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_e;

   // One decoded transaction, 103 bits
   typedef struct packed
   {
      access_e     write;     // Read or write
      datamode_e   datamode;  // Transfer size
      logic [3:0]  ctrlmode;  // Passed through untouched
      logic [31:0] dstaddr;
      logic [31:0] srcaddr;   // Return address for reads
      logic [31:0] data;
   } emesh_packet_t;

   // One parallel link beat
   typedef struct packed
   {
      logic [7:0]  frame;     // One frame bit per byte lane
      logic [63:0] data;      // Byte 0 in bits 7:0
   } rx_beat_t;

   localparam logic [7:0] FRAME_IDLE = 8'h00;   // Gap between packets
   localparam logic [7:0] FRAME_HEAD = 8'hFF;   // Header beat marker

   // Address top handling
   localparam int XLAT_W = 12;                                 // Translated top width
   localparam logic [XLAT_W-1:0] RR_WINDOW = 12'h810;          // Host response window

   // Default sizes
   localparam int DEF_MMU_IDX_W  = 4;   // Index from dstaddr 31:28
   localparam int DEF_FIFO_DEPTH = 8;

endpackage

/* common/axil_pkg.sv */
package axil_pkg;

   localparam int AXIL_AW = 16;   // Config address width
   localparam int AXIL_DW = 32;

   typedef enum logic [1:0]
   {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } resp_e;

   // Manager to subordinate
   typedef struct packed
   {
      logic               awvalid;
      logic [AXIL_AW-1:0] awaddr;
      logic               wvalid;
      logic [AXIL_DW-1:0] wdata;
      logic [3:0]         wstrb;
      logic               bready;
      logic               arvalid;
      logic [AXIL_AW-1:0] araddr;
      logic               rready;
   } axil_req_t;

   // Subordinate to manager
   typedef struct packed
   {
      logic               awready;
      logic               wready;
      logic               bvalid;
      resp_e              bresp;
      logic               arready;
      logic               rvalid;
      logic [AXIL_DW-1:0] rdata;
      resp_e              rresp;
   } axil_rsp_t;

endpackage

/* protocol/erx_decoder.sv */
`timescale 1ns/1ps

module erx_decoder
(
   input  logic                     rx_lclk_div4,
   input  logic                     rst_n,
   input  elink_pkg::rx_beat_t      beat,
   input  logic                     rx_enable,
   output logic                     dec_valid,
   output elink_pkg::emesh_packet_t dec_pkt
);

   typedef enum logic [1:0]
   {
      IDLE,      // Waiting for a header
      PAYLOAD,   // Header taken, next beat is payload
      SKIP       // Dropping trailing framed beats
   } state_e;

   state_e      state;
   logic        frame_zero_q;   // Previous beat was a gap
   logic        hdr_hit;
   logic        frame_idle;
   logic [7:0]  hdr_cmd;        // Command byte of header
   logic [31:0] hdr_dst;        // Destination from header

   assign frame_idle = (beat.frame == elink_pkg::FRAME_IDLE);

   // Rising frame edge only, and only when enabled
   assign hdr_hit = (state == IDLE) && (beat.frame == elink_pkg::FRAME_HEAD) &&
                    frame_zero_q && rx_enable;

   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state        <= IDLE;
         frame_zero_q <= 1'b0;
         dec_valid    <= 1'b0;
      end
      else
      begin
         frame_zero_q <= frame_idle;
         dec_valid    <= 1'b0;   // Single cycle strobe
         case (state)
            IDLE:
            begin
               if (hdr_hit)
                  state <= PAYLOAD;
            end
            PAYLOAD:
            begin
               dec_valid <= 1'b1;                   // Packet complete
               state     <= frame_idle ? IDLE : SKIP;   // Gap already seen
            end
            SKIP:
            begin
               if (frame_idle)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Header fields and assembled packet
   always_ff @(posedge rx_lclk_div4)
   begin
      if (hdr_hit)
      begin
         hdr_cmd <= beat.data[7:0];
         hdr_dst <= beat.data[39:8];   // Bytes 1 to 4
      end
      if (state == PAYLOAD)
      begin
         dec_pkt.write    <= elink_pkg::access_e'(hdr_cmd[0]);
         dec_pkt.datamode <= elink_pkg::datamode_e'(hdr_cmd[2:1]);
         dec_pkt.ctrlmode <= hdr_cmd[7:4];
         dec_pkt.dstaddr  <= hdr_dst;
         dec_pkt.data     <= beat.data[31:0];    // Bytes 0 to 3
         dec_pkt.srcaddr  <= beat.data[63:32];   // Bytes 4 to 7
      end
   end

endmodule

/* mmu/emmu_cfg.sv */
`timescale 1ns/1ps

module emmu_cfg #(
   parameter int MMU_IDX_W = elink_pkg::DEF_MMU_IDX_W
)
(
   input  logic                          rx_lclk_div4,
   input  logic                          rst_n,
   input  axil_pkg::axil_req_t           cfg_req,
   input  logic [elink_pkg::XLAT_W-1:0]  tbl_rdata,
   output axil_pkg::axil_rsp_t           cfg_rsp,
   output logic                          tbl_we,
   output logic [MMU_IDX_W-1:0]          tbl_waddr,
   output logic [elink_pkg::XLAT_W-1:0]  tbl_wdata,
   output logic [MMU_IDX_W-1:0]          tbl_raddr
);

   localparam int IDX_LSB = 2;   // Word addressed entries

   logic                         awready_q;
   logic                         arready_q;
   logic                         bvalid_q;
   logic                         rvalid_q;
   axil_pkg::resp_e              bresp_q;
   axil_pkg::resp_e              rresp_q;
   logic [axil_pkg::AXIL_DW-1:0] rdata_q;
   logic                         wr_hs;
   logic                         rd_hs;
   logic                         aw_in_range;
   logic                         ar_in_range;

   assign wr_hs = awready_q & cfg_req.awvalid & cfg_req.wvalid;   // AW and W together
   assign rd_hs = arready_q & cfg_req.arvalid;

   // Upper address bits must be zero
   assign aw_in_range = (cfg_req.awaddr[axil_pkg::AXIL_AW-1:IDX_LSB+MMU_IDX_W] == '0);
   assign ar_in_range = (cfg_req.araddr[axil_pkg::AXIL_AW-1:IDX_LSB+MMU_IDX_W] == '0);

   assign tbl_we    = wr_hs & aw_in_range;
   assign tbl_waddr = cfg_req.awaddr[IDX_LSB +: MMU_IDX_W];
   assign tbl_wdata = cfg_req.wdata[elink_pkg::XLAT_W-1:0];   // Upper bits dropped
   assign tbl_raddr = cfg_req.araddr[IDX_LSB +: MMU_IDX_W];

   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         awready_q <= 1'b0;
         arready_q <= 1'b0;
         bvalid_q  <= 1'b0;
         rvalid_q  <= 1'b0;
      end
      else
      begin
         // One outstanding write, ready pulses once
         awready_q <= cfg_req.awvalid & cfg_req.wvalid & ~awready_q & ~bvalid_q;
         if (wr_hs)
            bvalid_q <= 1'b1;
         else if (cfg_req.bready)
            bvalid_q <= 1'b0;
         // One outstanding read
         arready_q <= cfg_req.arvalid & ~arready_q & ~rvalid_q;
         if (rd_hs)
            rvalid_q <= 1'b1;
         else if (cfg_req.rready)
            rvalid_q <= 1'b0;
      end
   end

   // Response holding registers
   always_ff @(posedge rx_lclk_div4)
   begin
      if (wr_hs)
         bresp_q <= aw_in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      if (rd_hs)
      begin
         rdata_q <= ar_in_range ?
                    {{(axil_pkg::AXIL_DW-elink_pkg::XLAT_W){1'b0}}, tbl_rdata} : '0;
         rresp_q <= ar_in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      end
   end

   assign cfg_rsp.awready = awready_q;
   assign cfg_rsp.wready  = awready_q;   // W taken with AW
   assign cfg_rsp.bvalid  = bvalid_q;
   assign cfg_rsp.bresp   = bresp_q;
   assign cfg_rsp.arready = arready_q;
   assign cfg_rsp.rvalid  = rvalid_q;
   assign cfg_rsp.rdata   = rdata_q;
   assign cfg_rsp.rresp   = rresp_q;

endmodule

/* mmu/emmu.sv */
`timescale 1ns/1ps

module emmu #(
   parameter int MMU_IDX_W = elink_pkg::DEF_MMU_IDX_W
)
(
   input  logic                     rx_lclk_div4,
   input  logic                     rst_n,
   input  logic                     mmu_enable,
   input  logic                     dec_valid,
   input  elink_pkg::emesh_packet_t dec_pkt,
   input  axil_pkg::axil_req_t      cfg_req,
   output axil_pkg::axil_rsp_t      cfg_rsp,
   output logic                     mmu_valid,
   output elink_pkg::emesh_packet_t mmu_pkt
);

   localparam int ENTRIES = 2**MMU_IDX_W;

   logic [elink_pkg::XLAT_W-1:0] tbl [ENTRIES];   // Translation table
   logic                         tbl_we;
   logic [MMU_IDX_W-1:0]         tbl_waddr;
   logic [elink_pkg::XLAT_W-1:0] tbl_wdata;
   logic [MMU_IDX_W-1:0]         tbl_raddr;
   logic [elink_pkg::XLAT_W-1:0] tbl_rdata;
   logic [MMU_IDX_W-1:0]         xlat_idx;

   emmu_cfg #(.MMU_IDX_W(MMU_IDX_W)) emmu_cfg
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .cfg_req      (cfg_req),
      .tbl_rdata    (tbl_rdata),
      .cfg_rsp      (cfg_rsp),
      .tbl_we       (tbl_we),
      .tbl_waddr    (tbl_waddr),
      .tbl_wdata    (tbl_wdata),
      .tbl_raddr    (tbl_raddr)
   );

   // Entries come up as zero
   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < ENTRIES; i++)
            tbl[i] <= '0;
      end
      else if (tbl_we)
         tbl[tbl_waddr] <= tbl_wdata;
   end

   assign tbl_rdata = tbl[tbl_raddr];                   // Bus readback
   assign xlat_idx  = dec_pkt.dstaddr[31 -: MMU_IDX_W];   // Top bits pick entry

   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
         mmu_valid <= 1'b0;
      else
         mmu_valid <= dec_valid;
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (dec_valid)
      begin
         mmu_pkt <= dec_pkt;
         if (mmu_enable)
            mmu_pkt.dstaddr[31 -: elink_pkg::XLAT_W] <= tbl[xlat_idx];   // Replace top
      end
   end

endmodule

/* logic/erx_disty.sv */
`timescale 1ns/1ps

module erx_disty
(
   input  logic                     rx_lclk_div4,
   input  logic                     rst_n,
   input  logic                     mmu_valid,
   input  elink_pkg::emesh_packet_t mmu_pkt,
   input  logic                     wr_afull,
   input  logic                     rq_afull,
   input  logic                     rr_afull,
   input  logic                     wr_full,
   input  logic                     rq_full,
   input  logic                     rr_full,
   output logic                     wr_push,
   output logic                     rq_push,
   output logic                     rr_push,
   output elink_pkg::emesh_packet_t route_pkt,
   output logic                     rx_wr_wait,
   output logic                     rx_rd_wait
);

   logic is_read;
   logic is_rr;
   logic is_wr;

   // Classify by opcode and response window
   assign is_read = (mmu_pkt.write == elink_pkg::ACC_READ);
   assign is_rr   = ~is_read &&
                    (mmu_pkt.dstaddr[31 -: elink_pkg::XLAT_W] == elink_pkg::RR_WINDOW);
   assign is_wr   = ~is_read & ~is_rr;

   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_push    <= 1'b0;
         rq_push    <= 1'b0;
         rr_push    <= 1'b0;
         rx_wr_wait <= 1'b0;
         rx_rd_wait <= 1'b0;
      end
      else
      begin
         wr_push    <= mmu_valid & is_wr & ~wr_full;     // Dropped when full
         rq_push    <= mmu_valid & is_read & ~rq_full;
         rr_push    <= mmu_valid & is_rr & ~rr_full;
         rx_wr_wait <= wr_afull | rr_afull;              // Both write queues
         rx_rd_wait <= rq_afull;
      end
   end

   // Shared packet for all three queues
   always_ff @(posedge rx_lclk_div4)
   begin
      if (mmu_valid)
         route_pkt <= mmu_pkt;
   end

endmodule

/* logic/erx_fifo.sv */
`timescale 1ns/1ps

module erx_fifo #(
   parameter int DEPTH = elink_pkg::DEF_FIFO_DEPTH
)
(
   input  logic                     rx_lclk_div4,
   input  logic                     rst_n,
   input  logic                     push,
   input  elink_pkg::emesh_packet_t push_pkt,
   input  logic                     pop,
   output logic                     valid,
   output elink_pkg::emesh_packet_t head_pkt,
   output logic                     full,
   output logic                     almost_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);
   localparam logic [CNT_W-1:0] AFULL_CNT = CNT_W'(DEPTH - 2);   // Wait threshold

   elink_pkg::emesh_packet_t mem [DEPTH];
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;
   logic [CNT_W-1:0]         count;
   logic                     do_push;
   logic                     do_pop;

   assign valid       = (count != '0);
   assign full        = (count == FULL_CNT);
   assign almost_full = (count >= AFULL_CNT);
   assign head_pkt    = mem[rd_ptr];       // Show-ahead
   assign do_push     = push & ~full;      // Overflow guard
   assign do_pop      = pop & valid;

   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (do_push)
         mem[wr_ptr] <= push_pkt;
   end

endmodule

/* logic/erx.sv */
`timescale 1ns/1ps

module erx #(
   parameter int MMU_IDX_W  = elink_pkg::DEF_MMU_IDX_W,
   parameter int FIFO_DEPTH = elink_pkg::DEF_FIFO_DEPTH
)
(
   input  logic                     rx_lclk_div4,
   input  logic                     rst_n,
   input  elink_pkg::rx_beat_t      beat,
   input  logic                     rx_enable,
   input  logic                     mmu_enable,
   input  axil_pkg::axil_req_t      cfg_req,
   input  logic                     wr_ready,
   input  logic                     rq_ready,
   input  logic                     rr_ready,
   output axil_pkg::axil_rsp_t      cfg_rsp,
   output logic                     wr_valid,
   output elink_pkg::emesh_packet_t wr_pkt,
   output logic                     rq_valid,
   output elink_pkg::emesh_packet_t rq_pkt,
   output logic                     rr_valid,
   output logic [31:0]              rr_data,
   output logic                     rx_wr_wait,
   output logic                     rx_rd_wait
);

   logic                     dec_valid;
   elink_pkg::emesh_packet_t dec_pkt;
   logic                     mmu_valid;
   elink_pkg::emesh_packet_t mmu_pkt;
   elink_pkg::emesh_packet_t route_pkt;
   elink_pkg::emesh_packet_t rr_pkt;      // Only data leaves the block
   logic                     wr_push, rq_push, rr_push;
   logic                     wr_afull, rq_afull, rr_afull;
   logic                     wr_full, rq_full, rr_full;

   erx_decoder erx_decoder
   (
      .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .beat (beat),
      .rx_enable (rx_enable), .dec_valid (dec_valid), .dec_pkt (dec_pkt)
   );

   emmu #(.MMU_IDX_W(MMU_IDX_W)) emmu
   (
      .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .mmu_enable (mmu_enable),
      .dec_valid (dec_valid), .dec_pkt (dec_pkt), .cfg_req (cfg_req),
      .cfg_rsp (cfg_rsp), .mmu_valid (mmu_valid), .mmu_pkt (mmu_pkt)
   );

   erx_disty erx_disty
   (
      .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .mmu_valid (mmu_valid),
      .mmu_pkt (mmu_pkt), .wr_afull (wr_afull), .rq_afull (rq_afull),
      .rr_afull (rr_afull), .wr_full (wr_full), .rq_full (rq_full), .rr_full (rr_full),
      .wr_push (wr_push), .rq_push (rq_push), .rr_push (rr_push), .route_pkt (route_pkt),
      .rx_wr_wait (rx_wr_wait), .rx_rd_wait (rx_rd_wait)
   );

   // Writes
   erx_fifo #(.DEPTH(FIFO_DEPTH)) wr_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .push (wr_push), .push_pkt (route_pkt),
      .pop (wr_ready), .valid (wr_valid), .head_pkt (wr_pkt), .full (wr_full),
      .almost_full (wr_afull)
   );

   // Read requests
   erx_fifo #(.DEPTH(FIFO_DEPTH)) rq_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .push (rq_push), .push_pkt (route_pkt),
      .pop (rq_ready), .valid (rq_valid), .head_pkt (rq_pkt), .full (rq_full),
      .almost_full (rq_afull)
   );

   // Read responses for the host
   erx_fifo #(.DEPTH(FIFO_DEPTH)) rr_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .push (rr_push), .push_pkt (route_pkt),
      .pop (rr_ready), .valid (rr_valid), .head_pkt (rr_pkt), .full (rr_full),
      .almost_full (rr_afull)
   );

   assign rr_data = rr_pkt.data;

endmodule

/* testbench/erx_checker.sv */
`timescale 1ns/1ps

module erx_checker
(
   input logic rx_lclk_div4,
   input logic rst_n,
   input logic push,      // Queue write strobe
   input logic full,
   input logic q_valid,   // Queue head present
   input logic q_pop,
   input logic bvalid,
   input logic bready,
   input logic rvalid,
   input logic rready
);

   // Waits honored, so the distributor never meets a full queue
   no_push_when_full: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      push |-> !full)
      else $error("push into a full queue");

   q_head_held: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      q_valid && !q_pop |=> q_valid)
      else $error("queue head lost without a pop");

   b_held: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   r_held: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   quiet_in_reset: assert property (@(posedge rx_lclk_div4)
      !rst_n |-> !q_valid && !bvalid && !rvalid)
      else $error("valid high during reset");

endmodule

// Queue side, bus ports tied off
bind erx_fifo erx_checker i_fifo_chk
(
   .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .push (push), .full (full),
   .q_valid (valid), .q_pop (pop), .bvalid (1'b0), .bready (1'b0),
   .rvalid (1'b0), .rready (1'b0)
);

// Config bus side, queue ports tied off
bind emmu_cfg erx_checker i_cfg_chk
(
   .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .push (1'b0), .full (1'b0),
   .q_valid (1'b0), .q_pop (1'b0), .bvalid (cfg_rsp.bvalid), .bready (cfg_req.bready),
   .rvalid (cfg_rsp.rvalid), .rready (cfg_req.rready)
);

/* testbench/tb_erx.sv */
`timescale 1ns/1ps

module tb_erx;

   localparam int MMU_IDX_W  = elink_pkg::DEF_MMU_IDX_W;
   localparam int FIFO_DEPTH = elink_pkg::DEF_FIFO_DEPTH;
   localparam int ENTRIES    = 2**MMU_IDX_W;
   localparam int WAIT_LIMIT = 40;   // Cycles allowed per wait loop

   logic                         rx_lclk_div4;
   logic                         rst_n;
   elink_pkg::rx_beat_t          beat;
   logic                         rx_enable;
   logic                         mmu_enable;
   axil_pkg::axil_req_t          cfg_req;
   logic                         wr_ready;
   logic                         rq_ready;
   logic                         rr_ready;
   axil_pkg::axil_rsp_t          cfg_rsp;
   logic                         wr_valid;
   elink_pkg::emesh_packet_t     wr_pkt;
   logic                         rq_valid;
   elink_pkg::emesh_packet_t     rq_pkt;
   logic                         rr_valid;
   logic [31:0]                  rr_data;
   logic                         rx_wr_wait;
   logic                         rx_rd_wait;
   integer                       seed;
   logic [elink_pkg::XLAT_W-1:0] tbl_model [ENTRIES];   // Expected table contents

   erx #(.MMU_IDX_W(MMU_IDX_W), .FIFO_DEPTH(FIFO_DEPTH)) i_dut
   (
      .rx_lclk_div4 (rx_lclk_div4), .rst_n (rst_n), .beat (beat), .rx_enable (rx_enable),
      .mmu_enable (mmu_enable), .cfg_req (cfg_req), .wr_ready (wr_ready),
      .rq_ready (rq_ready), .rr_ready (rr_ready), .cfg_rsp (cfg_rsp),
      .wr_valid (wr_valid), .wr_pkt (wr_pkt), .rq_valid (rq_valid), .rq_pkt (rq_pkt),
      .rr_valid (rr_valid), .rr_data (rr_data), .rx_wr_wait (rx_wr_wait),
      .rx_rd_wait (rx_rd_wait)
   );

   initial
   begin
      rx_lclk_div4 = 1'b0;
      forever #50 rx_lclk_div4 = ~rx_lclk_div4;   // 100 ns period
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_pkt(input string name, input elink_pkg::emesh_packet_t got,
                            input elink_pkg::emesh_packet_t exp);
      if (got !== exp)
         abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_resp(input string name, input axil_pkg::resp_e got,
                             input axil_pkg::resp_e exp);
      if (got !== exp)
         abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
   endtask

   function automatic logic read_flag(input string name);
      case (name)
         "wr_valid":   return wr_valid;
         "rq_valid":   return rq_valid;
         "rr_valid":   return rr_valid;
         "rx_wr_wait": return rx_wr_wait;
         "awready":    return cfg_rsp.awready;
         "bvalid":     return cfg_rsp.bvalid;
         "arready":    return cfg_rsp.arready;
         "rvalid":     return cfg_rsp.rvalid;
         default:      return 1'bx;
      endcase
   endfunction

   // Polls on the falling edge away from DUT updates
   task automatic await_level(input string name, input logic level);
      int cycles;
      cycles = 0;
      @(negedge rx_lclk_div4);
      while (read_flag(name) !== level)
      begin
         cycles++;
         if (cycles > WAIT_LIMIT)
            abort_run($sformatf("Timed out waiting for %s to reach %0d", name, level));
         else
            @(negedge rx_lclk_div4);
      end
   endtask

   function automatic elink_pkg::emesh_packet_t random_pkt(input elink_pkg::access_e acc);
      elink_pkg::emesh_packet_t pkt;
      logic [31:0]              r;
      r            = $random(seed);
      pkt.write    = acc;
      pkt.datamode = elink_pkg::datamode_e'(r[2:1]);
      pkt.ctrlmode = r[7:4];
      pkt.dstaddr  = $random(seed);
      pkt.srcaddr  = $random(seed);
      pkt.data     = $random(seed);
      if (pkt.dstaddr[31:20] == elink_pkg::RR_WINDOW)
         pkt.dstaddr[20] = ~pkt.dstaddr[20];   // Stay out of the response window
      return pkt;
   endfunction

   // Header, payload, then one gap beat
   task automatic send_pkt(input elink_pkg::emesh_packet_t pkt);
      @(posedge rx_lclk_div4);
      beat <= {8'hFF, 24'h0, pkt.dstaddr, pkt.ctrlmode, 1'b0, pkt.datamode, pkt.write};
      @(posedge rx_lclk_div4);
      beat <= {8'hFF, pkt.srcaddr, pkt.data};   // Data low, srcaddr high
      @(posedge rx_lclk_div4);
      beat <= '0;
   endtask

   task automatic pop_queue(input string queue);
      @(posedge rx_lclk_div4);
      case (queue)
         "wr":    wr_ready <= 1'b1;
         "rq":    rq_ready <= 1'b1;
         default: rr_ready <= 1'b1;
      endcase
      @(posedge rx_lclk_div4);
      wr_ready <= 1'b0;
      rq_ready <= 1'b0;
      rr_ready <= 1'b0;
   endtask

   task automatic take_packet(input string queue, input elink_pkg::emesh_packet_t exp);
      await_level({queue, "_valid"}, 1'b1);
      case (queue)
         "wr":    check_pkt("wr_pkt", wr_pkt, exp);
         "rq":    check_pkt("rq_pkt", rq_pkt, exp);
         default: check_data("rr_data", rr_data, exp.data);   // Only data leaves rr
      endcase
      pop_queue(queue);
   endtask

   task automatic cfg_write(input int idx, input logic [31:0] value);
      @(posedge rx_lclk_div4);
      cfg_req.awvalid <= 1'b1;
      cfg_req.awaddr  <= 16'(idx * 4);   // Word per entry
      cfg_req.wvalid  <= 1'b1;
      cfg_req.wdata   <= value;
      cfg_req.wstrb   <= 4'hF;
      await_level("awready", 1'b1);
      check_bit("wready", cfg_rsp.wready, 1'b1);   // W accepted together with AW
      @(posedge rx_lclk_div4);
      cfg_req.awvalid <= 1'b0;
      cfg_req.wvalid  <= 1'b0;
      await_level("bvalid", 1'b1);
      check_bit("wready", cfg_rsp.wready, 1'b0);   // Single cycle pulse
      check_resp("bresp", cfg_rsp.bresp, axil_pkg::RESP_OKAY);
      @(posedge rx_lclk_div4);
      cfg_req.bready <= 1'b1;
      @(posedge rx_lclk_div4);
      cfg_req.bready <= 1'b0;
      tbl_model[idx] = value[elink_pkg::XLAT_W-1:0];   // Only low 12 bits kept
   endtask

   task automatic cfg_read_check(input int idx);
      @(posedge rx_lclk_div4);
      cfg_req.arvalid <= 1'b1;
      cfg_req.araddr  <= 16'(idx * 4);
      await_level("arready", 1'b1);
      @(posedge rx_lclk_div4);
      cfg_req.arvalid <= 1'b0;
      await_level("rvalid", 1'b1);
      check_data("rdata", cfg_rsp.rdata, {20'h0, tbl_model[idx]});
      check_resp("rresp", cfg_rsp.rresp, axil_pkg::RESP_OKAY);
      @(posedge rx_lclk_div4);
      cfg_req.rready <= 1'b1;
      @(posedge rx_lclk_div4);
      cfg_req.rready <= 1'b0;
   endtask

   task automatic test_reset_state();
      @(negedge rx_lclk_div4);
      check_bit("wr_valid", wr_valid, 1'b0);
      check_bit("rq_valid", rq_valid, 1'b0);
      check_bit("rr_valid", rr_valid, 1'b0);
      check_bit("rx_wr_wait", rx_wr_wait, 1'b0);
      check_bit("rx_rd_wait", rx_rd_wait, 1'b0);
      check_bit("bvalid", cfg_rsp.bvalid, 1'b0);
      check_bit("rvalid", cfg_rsp.rvalid, 1'b0);
   endtask

   task automatic test_table_access();
      cfg_write(5, $random(seed));
      cfg_read_check(5);
      cfg_read_check(9);   // Untouched entry reads zero
   endtask

   task automatic test_passthrough();
      elink_pkg::emesh_packet_t wpkt;
      elink_pkg::emesh_packet_t rpkt;
      wpkt = random_pkt(elink_pkg::ACC_WRITE);
      rpkt = random_pkt(elink_pkg::ACC_READ);
      send_pkt(wpkt);
      send_pkt(rpkt);
      take_packet("wr", wpkt);
      take_packet("rq", rpkt);
   endtask

   task automatic test_response_window();
      elink_pkg::emesh_packet_t pkt;
      pkt                = random_pkt(elink_pkg::ACC_WRITE);
      pkt.dstaddr[31:20] = elink_pkg::RR_WINDOW;
      send_pkt(pkt);
      await_level("rr_valid", 1'b1);
      check_bit("wr_valid", wr_valid, 1'b0);   // Nothing leaks to other queues
      check_bit("rq_valid", rq_valid, 1'b0);
      take_packet("rr", pkt);
   endtask

   task automatic test_translation();
      elink_pkg::emesh_packet_t pkt;
      elink_pkg::emesh_packet_t exp;
      logic [31:0]              entry;
      for (int i = 0; i < ENTRIES; i++)
      begin
         entry = $random(seed);
         if (entry[11:0] == elink_pkg::RR_WINDOW)
            entry[0] = ~entry[0];   // Translated writes stay on wr
         cfg_write(i, entry);
      end
      @(posedge rx_lclk_div4);
      mmu_enable <= 1'b1;
      for (int n = 0; n < 4; n++)
      begin
         pkt                = random_pkt(n == 3 ? elink_pkg::ACC_READ : elink_pkg::ACC_WRITE);
         exp                = pkt;
         exp.dstaddr[31:20] = tbl_model[pkt.dstaddr[31:28]];   // Top 4 bits pick entry
         send_pkt(pkt);
         take_packet(n == 3 ? "rq" : "wr", exp);
      end
      @(posedge rx_lclk_div4);
      mmu_enable <= 1'b0;
   endtask

   task automatic test_backpressure();
      elink_pkg::emesh_packet_t sent [FIFO_DEPTH-2];
      for (int i = 0; i < FIFO_DEPTH-2; i++)
      begin
         sent[i] = random_pkt(elink_pkg::ACC_WRITE);
         if (i == FIFO_DEPTH-3)
         begin
            repeat (6) @(posedge rx_lclk_div4);   // 4 cycle path plus wait register
            @(negedge rx_lclk_div4);
         end
         check_bit("rx_wr_wait", rx_wr_wait, 1'b0);   // Sender may still start
         send_pkt(sent[i]);
      end
      await_level("rx_wr_wait", 1'b1);
      for (int i = 0; i < FIFO_DEPTH-2; i++)
         take_packet("wr", sent[i]);   // Order kept
      await_level("rx_wr_wait", 1'b0);
      check_bit("wr_valid", wr_valid, 1'b0);
   endtask

   initial
   begin
      seed       = 32'h0314_19f4;
      rst_n      = 1'b0;
      beat       = '0;
      rx_enable  = 1'b0;
      mmu_enable = 1'b0;
      cfg_req    = '0;
      wr_ready   = 1'b0;
      rq_ready   = 1'b0;
      rr_ready   = 1'b0;
      for (int i = 0; i < ENTRIES; i++)
         tbl_model[i] = '0;   // Table clears on reset
      repeat (10) @(posedge rx_lclk_div4);
      rst_n     <= 1'b1;
      rx_enable <= 1'b1;
      test_reset_state();
      test_table_access();
      test_passthrough();
      test_response_window();
      test_translation();
      test_backpressure();
      $display("TEST PASSED");
      $finish;
   end

endmodule

/* sources.f */
common/elink_pkg.sv
common/axil_pkg.sv
protocol/erx_decoder.sv
mmu/emmu_cfg.sv
mmu/emmu.sv
logic/erx_disty.sv
logic/erx_fifo.sv
logic/erx.sv
testbench/erx_checker.sv
testbench/tb_erx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the erx testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_erx -f sources.f -o sim_erx

# A failing run still reaches the log check below
./obj_dir/sim_erx | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
   echo "Simulation result: pass"
else
   echo "Simulation result: fail"
   exit 1
fi
